// File: include/tcdm_params.svh
`ifndef TCDM_PARAMS_SVH
`define TCDM_PARAMS_SVH

// Word address into one bank, 1024 words
`define TCDM_ADDR_WIDTH 10

// Data word, only 32 bits are supported
`define TCDM_DATA_WIDTH 32

// Requesting core and transaction tag carried in the metadata
`define TCDM_CORE_ID_WIDTH 4
`define TCDM_TAG_WIDTH 4

// 1 puts a register between the AMO ALU and the SRAM write
`define TCDM_REGISTER_AMO 0

`endif

// File: source/tcdm_pkg.sv
`default_nettype none

`include "tcdm_params.svh"

package tcdm_pkg;

  // ------------------------------------------------------------------
  // Data path types
  // ------------------------------------------------------------------

  typedef logic [`TCDM_DATA_WIDTH-1:0]   tcdm_word_t;
  typedef logic [`TCDM_DATA_WIDTH/8-1:0] tcdm_be_t;
  typedef logic [`TCDM_ADDR_WIDTH-1:0]   tcdm_addr_t;

  // Travels with a request and comes back unchanged with its response
  typedef struct packed {
    logic [`TCDM_CORE_ID_WIDTH-1:0] core_id;
    logic [`TCDM_TAG_WIDTH-1:0]     tag;
  } tcdm_meta_t;

  // ------------------------------------------------------------------
  // Atomic opcodes
  // ------------------------------------------------------------------

  typedef enum logic [3:0] {
    AmoNone = 4'h0,
    AmoSwap = 4'h1,
    AmoAdd  = 4'h2,
    AmoAnd  = 4'h3,
    AmoOr   = 4'h4,
    AmoXor  = 4'h5,
    AmoMax  = 4'h6,
    AmoMaxu = 4'h7,
    AmoMin  = 4'h8,
    AmoMinu = 4'h9,
    AmoLr   = 4'hA,
    AmoSc   = 4'hB
  } amo_op_t;

endpackage

`default_nettype wire

// File: source/spill_register.sv
`timescale 1ns/1ps
`default_nettype none

module spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  // Input side
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  // Output side
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Slot a takes new items, slot b holds an item the consumer refused
  logic a_full_q;
  logic b_full_q;
  T     a_data_q;
  T     b_data_q;
  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  assign a_fill  = valid_i && ready_o;
  // Slot a empties whenever b has room, either to the output or into b
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  // Payload slots
  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Ready only looks at local state, so ready_i never reaches ready_o
  assign ready_o = !a_full_q || !b_full_q;
  // Older item sits in b when both are full
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

`default_nettype wire

// File: source/fall_through_register.sv
`timescale 1ns/1ps
`default_nettype none

module fall_through_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  // Input side
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  // Output side
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic full_q;
  T     data_q;
  logic capture;

  // Input goes straight out while empty
  assign valid_o = full_q || valid_i;
  assign data_o  = full_q ? data_q : data_i;
  assign ready_o = !full_q;

  // Keep the item only if nobody took it this cycle
  assign capture = valid_i && !full_q && !ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (capture) begin
      full_q <= 1'b1;
    end else if (full_q && ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Held word
  always_ff @(posedge clk_i) begin
    if (capture) begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: source/amo_alu.sv
`timescale 1ns/1ps
`default_nettype none

module amo_alu (
  input  tcdm_pkg::amo_op_t    op_i,
  input  tcdm_pkg::tcdm_word_t mem_word_i,
  input  tcdm_pkg::tcdm_word_t operand_i,
  output tcdm_pkg::tcdm_word_t result_o
);

  import tcdm_pkg::*;

  localparam int unsigned W = $bits(tcdm_word_t);

  logic         cmp_signed;
  logic [W:0]   cmp_a;
  logic [W:0]   cmp_b;
  logic [W:0]   cmp_diff;
  logic         mem_lt_op;
  tcdm_word_t   sum;

  // ------------------------------------------------------------------
  // Shared comparator
  // ------------------------------------------------------------------

  // Sign extend for max/min, zero extend for the unsigned pair
  assign cmp_signed = (op_i == AmoMax) || (op_i == AmoMin);
  assign cmp_a      = {cmp_signed & mem_word_i[W-1], mem_word_i};
  assign cmp_b      = {cmp_signed & operand_i[W-1], operand_i};

  // Difference always fits in W+1 bits, so its top bit is the sign
  assign cmp_diff  = cmp_a - cmp_b;
  assign mem_lt_op = cmp_diff[W];

  assign sum = mem_word_i + operand_i;

  // ------------------------------------------------------------------
  // Result select
  // ------------------------------------------------------------------

  always_comb begin
    // Swap and anything unexpected write the operand
    result_o = operand_i;
    case (op_i)
      AmoAdd:  result_o = sum;
      AmoAnd:  result_o = mem_word_i & operand_i;
      AmoOr:   result_o = mem_word_i | operand_i;
      AmoXor:  result_o = mem_word_i ^ operand_i;
      // Larger of the two
      AmoMax,
      AmoMaxu: result_o = mem_lt_op ? operand_i : mem_word_i;
      // Smaller of the two
      AmoMin,
      AmoMinu: result_o = mem_lt_op ? mem_word_i : operand_i;
      default: result_o = operand_i;
    endcase
  end

endmodule

`default_nettype wire

// File: source/tcdm_adapter.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_params.svh"

module tcdm_adapter #(
  // Extra cycle between ALU and write-back
  parameter bit RegisterAmo = 1'b0
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Request from the interconnect
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  tcdm_pkg::tcdm_addr_t in_addr_i,
  input  tcdm_pkg::amo_op_t    in_amo_i,
  input  logic                 in_write_i,
  input  tcdm_pkg::tcdm_word_t in_wdata_i,
  input  tcdm_pkg::tcdm_be_t   in_be_i,
  input  tcdm_pkg::tcdm_meta_t in_meta_i,
  // Response to the interconnect
  output logic                 in_valid_o,
  input  logic                 in_ready_i,
  output tcdm_pkg::tcdm_word_t in_rdata_o,
  output tcdm_pkg::tcdm_meta_t in_meta_o,
  // SRAM command, fixed one cycle read latency
  output logic                 mem_req_o,
  output logic                 mem_write_o,
  output tcdm_pkg::tcdm_addr_t mem_addr_o,
  output tcdm_pkg::tcdm_word_t mem_wdata_o,
  output tcdm_pkg::tcdm_be_t   mem_be_o,
  input  tcdm_pkg::tcdm_word_t mem_rdata_i
);

  import tcdm_pkg::*;

  typedef enum logic [1:0] {
    Idle,
    DoAmo,
    WriteBackAmo
  } state_e;

  state_e state_q;
  state_e state_d;

  // Request decode
  logic accept;
  logic is_store;
  logic is_amo;
  logic wb_cycle;

  // Response path
  logic       meta_ready;
  logic       meta_valid;
  logic       rdata_ready;
  logic       rdata_valid;
  logic       pop_resp;
  logic       rsp_push_q;
  tcdm_word_t rsp_word;

  // LR/SC
  logic                           sc_successful;
  logic                           sc_q;
  logic                           sc_ok_q;
  logic                           resv_valid_q;
  logic                           resv_valid_d;
  tcdm_addr_t                     resv_addr_q;
  tcdm_addr_t                     resv_addr_d;
  logic [`TCDM_CORE_ID_WIDTH-1:0] resv_core_q;
  logic [`TCDM_CORE_ID_WIDTH-1:0] resv_core_d;

  // Latched atomic
  amo_op_t    amo_op_q;
  tcdm_addr_t amo_addr_q;
  tcdm_word_t amo_operand_q;
  tcdm_word_t amo_result;
  tcdm_word_t amo_wb_data;

  // Plain store carries no response, atomics need a write-back
  assign is_store = in_write_i && (in_amo_i == AmoNone);
  assign is_amo   = !(in_amo_i inside {AmoNone, AmoLr, AmoSc});

  // Stall on a refused response, or while the AMO owns the SRAM
  assign in_ready_o = (state_q == Idle) && meta_ready && (rdata_ready || in_ready_i)
                      && !(in_valid_o && !in_ready_i);
  assign accept     = in_valid_i && in_ready_o;

  // ------------------------------------------------------------------
  // Response registers
  // ------------------------------------------------------------------

  // Metadata of every request that expects an answer
  spill_register #(
    .T (tcdm_meta_t)
  ) i_meta_register (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (accept && !is_store),
    .ready_o (meta_ready),
    .data_i  (in_meta_i),
    .valid_o (meta_valid),
    .ready_i (pop_resp),
    .data_o  (in_meta_o)
  );

  // One cycle after a read or SC, the answer word arrives
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_push_q <= 1'b0;
      sc_q       <= 1'b0;
      sc_ok_q    <= 1'b0;
    end else begin
      rsp_push_q <= accept && !is_store;
      sc_q       <= accept && (in_amo_i == AmoSc);
      sc_ok_q    <= sc_successful;
    end
  end

  // SC answers 0 on success, 1 on failure
  assign rsp_word = sc_q ? {{(`TCDM_DATA_WIDTH-1){1'b0}}, !sc_ok_q} : mem_rdata_i;

  fall_through_register #(
    .T (tcdm_word_t)
  ) i_rdata_register (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (rsp_push_q),
    .ready_o (rdata_ready),
    .data_i  (rsp_word),
    .valid_o (rdata_valid),
    .ready_i (pop_resp),
    .data_o  (in_rdata_o)
  );

  // Both halves pop together
  assign in_valid_o = meta_valid && rdata_valid;
  assign pop_resp   = in_valid_o && in_ready_i;

  // ------------------------------------------------------------------
  // Reservation tracking
  // ------------------------------------------------------------------

  always_comb begin
    resv_valid_d  = resv_valid_q;
    resv_addr_d   = resv_addr_q;
    resv_core_d   = resv_core_q;
    sc_successful = 1'b0;
    if (accept) begin
      // LR may not steal another core's reservation
      if ((in_amo_i == AmoLr) && (!resv_valid_q || (resv_core_q == in_meta_i.core_id))) begin
        resv_valid_d = 1'b1;
        resv_addr_d  = in_addr_i;
        resv_core_d  = in_meta_i.core_id;
      end
      // Foreign write to the reserved word
      if ((resv_core_q != in_meta_i.core_id) && (resv_addr_q == in_addr_i)
          && (is_store || is_amo)) begin
        resv_valid_d = 1'b0;
      end
      // Owner's SC always ends the reservation
      if (resv_valid_q && (in_amo_i == AmoSc) && (resv_core_q == in_meta_i.core_id)) begin
        resv_valid_d  = 1'b0;
        sc_successful = (resv_addr_q == in_addr_i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resv_valid_q <= 1'b0;
      resv_addr_q  <= '0;
      resv_core_q  <= '0;
    end else begin
      resv_valid_q <= resv_valid_d;
      resv_addr_q  <= resv_addr_d;
      resv_core_q  <= resv_core_d;
    end
  end

  // ------------------------------------------------------------------
  // Atomic sequencer
  // ------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle:         if (accept && is_amo) state_d = DoAmo;
      DoAmo:        state_d = RegisterAmo ? WriteBackAmo : Idle;
      WriteBackAmo: state_d = Idle;
      default:      state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Opcode, address and operand of the atomic in flight
  always_ff @(posedge clk_i) begin
    if (accept && is_amo) begin
      amo_op_q      <= in_amo_i;
      amo_addr_q    <= in_addr_i;
      amo_operand_q <= in_wdata_i;
    end
  end

  // Old word is on mem_rdata_i during DoAmo
  amo_alu i_amo_alu (
    .op_i       (amo_op_q),
    .mem_word_i (mem_rdata_i),
    .operand_i  (amo_operand_q),
    .result_o   (amo_result)
  );

  if (RegisterAmo) begin : gen_amo_reg
    always_ff @(posedge clk_i) begin
      if (state_q == DoAmo) begin
        amo_wb_data <= amo_result;
      end
    end
  end else begin : gen_amo_direct
    assign amo_wb_data = amo_result;
  end

  assign wb_cycle = (state_q == WriteBackAmo) || ((state_q == DoAmo) && !RegisterAmo);

  // ------------------------------------------------------------------
  // SRAM command
  // ------------------------------------------------------------------

  always_comb begin
    if (wb_cycle) begin
      // Full word write-back of the ALU result
      mem_req_o   = 1'b1;
      mem_write_o = 1'b1;
      mem_addr_o  = amo_addr_q;
      mem_wdata_o = amo_wb_data;
      mem_be_o    = '1;
    end else begin
      // Pass-through, SC writes only on success
      mem_req_o   = accept;
      mem_write_o = is_store || sc_successful;
      mem_addr_o  = in_addr_i;
      mem_wdata_o = in_wdata_i;
      mem_be_o    = in_be_i;
    end
  end

endmodule

`default_nettype wire

// File: source/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_params.svh"

module sram_bank (
  input  logic                 clk_i,
  input  logic                 req_i,
  input  logic                 write_i,
  input  tcdm_pkg::tcdm_addr_t addr_i,
  input  tcdm_pkg::tcdm_word_t wdata_i,
  input  tcdm_pkg::tcdm_be_t   be_i,
  output tcdm_pkg::tcdm_word_t rdata_o
);

  import tcdm_pkg::*;

  localparam int unsigned Depth    = 1 << `TCDM_ADDR_WIDTH;
  localparam int unsigned NumBytes = $bits(tcdm_be_t);

  tcdm_word_t mem_q [Depth];

  // Write lands at the request edge, read word shows up after it
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        for (int unsigned b = 0; b < NumBytes; b++) begin
          // Only strobed bytes change
          if (be_i[b]) begin
            mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/tcdm_bank_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_params.svh"

module tcdm_bank_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Request channel
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  tcdm_pkg::tcdm_addr_t req_addr_i,
  input  tcdm_pkg::amo_op_t    req_amo_i,
  input  logic                 req_write_i,
  input  tcdm_pkg::tcdm_word_t req_wdata_i,
  input  tcdm_pkg::tcdm_be_t   req_be_i,
  input  tcdm_pkg::tcdm_meta_t req_meta_i,
  // Response channel
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i,
  output tcdm_pkg::tcdm_word_t rsp_rdata_o,
  output tcdm_pkg::tcdm_meta_t rsp_meta_o
);

  import tcdm_pkg::*;

  // Adapter to SRAM
  logic       mem_req;
  logic       mem_write;
  tcdm_addr_t mem_addr;
  tcdm_word_t mem_wdata;
  tcdm_be_t   mem_be;
  tcdm_word_t mem_rdata;

  tcdm_adapter #(
    .RegisterAmo (`TCDM_REGISTER_AMO)
  ) i_adapter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .in_addr_i   (req_addr_i),
    .in_amo_i    (req_amo_i),
    .in_write_i  (req_write_i),
    .in_wdata_i  (req_wdata_i),
    .in_be_i     (req_be_i),
    .in_meta_i   (req_meta_i),
    .in_valid_o  (rsp_valid_o),
    .in_ready_i  (rsp_ready_i),
    .in_rdata_o  (rsp_rdata_o),
    .in_meta_o   (rsp_meta_o),
    .mem_req_o   (mem_req),
    .mem_write_o (mem_write),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_be_o    (mem_be),
    .mem_rdata_i (mem_rdata)
  );

  sram_bank i_sram (
    .clk_i   (clk_i),
    .req_i   (mem_req),
    .write_i (mem_write),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .be_i    (mem_be),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

// File: verif/tb_tcdm_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_params.svh"

module tb_tcdm_bank;

  import tcdm_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 8;
  localparam int RSP_TIMEOUT  = 20;
  localparam int CORE_W       = `TCDM_CORE_ID_WIDTH;
  localparam int N_STORE_LOAD = 16;
  localparam int N_PARTIAL    = 8;
  localparam int N_AMO_ROUNDS = 3;
  localparam int N_BP         = 6;
  // Operations issued over all tests, sizes the watchdog
  localparam int NUM_OPS = 2*N_STORE_LOAD + 3*N_PARTIAL + 9*3*N_AMO_ROUNDS + 10 + 2*N_BP;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40*NUM_OPS;

  logic       clk_i;
  logic       rst_ni;
  logic       req_valid_i;
  logic       req_ready_o;
  tcdm_addr_t req_addr_i;
  amo_op_t    req_amo_i;
  logic       req_write_i;
  tcdm_word_t req_wdata_i;
  tcdm_be_t   req_be_i;
  tcdm_meta_t req_meta_i;
  logic       rsp_valid_o;
  logic       rsp_ready_i;
  tcdm_word_t rsp_rdata_o;
  tcdm_meta_t rsp_meta_o;

  // Reference memory and reservation record
  tcdm_word_t              model_mem [1 << `TCDM_ADDR_WIDTH];
  logic                    resv_valid_m = 1'b0;
  tcdm_addr_t              resv_addr_m  = '0;
  logic [CORE_W-1:0]       resv_core_m  = '0;

  logic [31:0]                lfsr_q = 32'd79723;
  logic [`TCDM_TAG_WIDTH-1:0] tag_q  = '0;
  int checks       = 0;
  int mismatches   = 0;
  int other_errors = 0;

  tcdm_bank_top uut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_addr_i  (req_addr_i),
    .req_amo_i   (req_amo_i),
    .req_write_i (req_write_i),
    .req_wdata_i (req_wdata_i),
    .req_be_i    (req_be_i),
    .req_meta_i  (req_meta_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_meta_o  (rsp_meta_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  // ------------------------------------------------------------------
  // Random numbers and reference model
  // ------------------------------------------------------------------

  // Galois form, taps 32 30 26 25
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic tcdm_word_t random_bits(input int n);
    tcdm_word_t r;
    int         i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [CORE_W-1:0] random_core();
    return CORE_W'(random_bits(CORE_W));
  endfunction

  function automatic tcdm_meta_t next_meta(input logic [CORE_W-1:0] core);
    tcdm_meta_t m;
    m.core_id = core;
    m.tag     = tag_q;
    tag_q     = tag_q + 1'b1;
    return m;
  endfunction

  // New memory word for each atomic, straight from the RV32A definitions
  function automatic tcdm_word_t ref_amo(input amo_op_t op, input tcdm_word_t old,
                                         input tcdm_word_t opd);
    case (op)
      AmoAdd:  return old + opd;
      AmoAnd:  return old & opd;
      AmoOr:   return old | opd;
      AmoXor:  return old ^ opd;
      AmoMax:  return ($signed(old) > $signed(opd)) ? old : opd;
      AmoMaxu: return (old > opd) ? old : opd;
      AmoMin:  return ($signed(old) < $signed(opd)) ? old : opd;
      AmoMinu: return (old < opd) ? old : opd;
      default: return opd;
    endcase
  endfunction

  function automatic void model_write(input tcdm_addr_t addr, input tcdm_word_t wdata,
                                      input tcdm_be_t be);
    int b;
    for (b = 0; b < 4; b++) begin
      if (be[b]) model_mem[addr][8*b +: 8] = wdata[8*b +: 8];
    end
  endfunction

  // A write by some other core kills the reservation on that word
  function automatic void drop_foreign(input logic [CORE_W-1:0] core, input tcdm_addr_t addr);
    if (resv_valid_m && (core != resv_core_m) && (addr == resv_addr_m)) resv_valid_m = 1'b0;
  endfunction

  // ------------------------------------------------------------------
  // Checks and bus tasks
  // ------------------------------------------------------------------

  task automatic check_rdata(input tcdm_word_t got, input tcdm_word_t exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch rsp_rdata_o at %0t: got 0x%08h, expected 0x%08h", $time, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_meta(input tcdm_meta_t got, input tcdm_meta_t exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch rsp_meta_o at %0t: got 0x%02h, expected 0x%02h", $time, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch %s at %0t: got 0x%0h, expected 0x%0h", name, $time, got, exp);
      mismatches++;
    end
  endtask

  // Called right after a falling edge, returns after the accepting edge
  task automatic send_request(input tcdm_addr_t addr, input amo_op_t op, input logic write,
                              input tcdm_word_t wdata, input tcdm_be_t be,
                              input tcdm_meta_t meta);
    int waited;
    waited      = 0;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_amo_i   = op;
    req_write_i = write;
    req_wdata_i = wdata;
    req_be_i    = be;
    req_meta_i  = meta;
    // Sample ready well inside the low phase
    #1;
    while (!req_ready_o && (waited < RSP_TIMEOUT)) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!req_ready_o) begin
      $display("Error: request to address 0x%03h not accepted within %0d cycles", addr,
               RSP_TIMEOUT);
      other_errors++;
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  // Expects rsp_ready_i high, so the response pops at the next rising edge
  task automatic await_response(input tcdm_word_t exp_data, input tcdm_meta_t exp_meta);
    int waited;
    waited = 0;
    #1;
    while (!rsp_valid_o && (waited < RSP_TIMEOUT)) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (rsp_valid_o) begin
      check_rdata(rsp_rdata_o, exp_data);
      check_meta(rsp_meta_o, exp_meta);
    end else begin
      $display("Error: no response for tag 0x%0h within %0d cycles", exp_meta.tag, RSP_TIMEOUT);
      other_errors++;
    end
    @(negedge clk_i);
  endtask

  // Predict with the model, issue the request, then check any response
  task automatic run_op(input tcdm_addr_t addr, input amo_op_t op, input logic write,
                        input tcdm_word_t wdata, input tcdm_be_t be,
                        input logic [CORE_W-1:0] core);
    tcdm_meta_t meta;
    tcdm_word_t exp;
    logic       has_rsp;
    logic       sc_ok;
    meta    = next_meta(core);
    has_rsp = 1'b1;
    exp     = model_mem[addr];
    case (op)
      AmoNone: begin
        if (write) begin
          has_rsp = 1'b0;
          drop_foreign(core, addr);
          model_write(addr, wdata, be);
        end
      end
      AmoLr: begin
        if (!resv_valid_m || (resv_core_m == core)) begin
          resv_valid_m = 1'b1;
          resv_addr_m  = addr;
          resv_core_m  = core;
        end
      end
      AmoSc: begin
        sc_ok = resv_valid_m && (resv_core_m == core) && (resv_addr_m == addr);
        if (resv_valid_m && (resv_core_m == core)) resv_valid_m = 1'b0;
        if (sc_ok) model_write(addr, wdata, be);
        exp = sc_ok ? 32'd0 : 32'd1;
      end
      default: begin
        drop_foreign(core, addr);
        model_mem[addr] = ref_amo(op, exp, wdata);
      end
    endcase
    send_request(addr, op, write, wdata, be, meta);
    if (has_rsp) await_response(exp, meta);
  endtask

  // ------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------

  task automatic store_load_test();
    tcdm_addr_t        addrs [N_STORE_LOAD];
    tcdm_word_t        wdata;
    logic [CORE_W-1:0] core;
    int                i;
    for (i = 0; i < N_STORE_LOAD; i++) begin
      addrs[i] = tcdm_addr_t'(random_bits(`TCDM_ADDR_WIDTH));
      wdata    = random_bits(32);
      core     = random_core();
      run_op(addrs[i], AmoNone, 1'b1, wdata, 4'hF, core);
    end
    for (i = 0; i < N_STORE_LOAD; i++) begin
      core = random_core();
      run_op(addrs[i], AmoNone, 1'b0, '0, 4'h0, core);
    end
  endtask

  task automatic partial_store_test();
    tcdm_addr_t        addr;
    tcdm_word_t        wdata;
    tcdm_be_t          be;
    logic [CORE_W-1:0] core;
    int                i;
    for (i = 0; i < N_PARTIAL; i++) begin
      addr  = tcdm_addr_t'(random_bits(`TCDM_ADDR_WIDTH));
      core  = random_core();
      wdata = random_bits(32);
      run_op(addr, AmoNone, 1'b1, wdata, 4'hF, core);
      wdata = random_bits(32);
      be    = tcdm_be_t'(random_bits(4));
      run_op(addr, AmoNone, 1'b1, wdata, be, core);
      run_op(addr, AmoNone, 1'b0, '0, 4'h0, core);
    end
  endtask

  task automatic atomic_test();
    tcdm_addr_t        addr;
    tcdm_word_t        old;
    tcdm_word_t        opd;
    logic [CORE_W-1:0] core;
    amo_op_t           op;
    int                k;
    int                r;
    for (k = 1; k <= 9; k++) begin
      op = amo_op_t'(k[3:0]);
      for (r = 0; r < N_AMO_ROUNDS; r++) begin
        addr = tcdm_addr_t'(random_bits(`TCDM_ADDR_WIDTH));
        old  = random_bits(32);
        opd  = random_bits(32);
        core = random_core();
        // Opposite signs tell signed and unsigned compares apart
        if (r == 1) begin
          old[31] = 1'b1;
          opd[31] = 1'b0;
        end
        if (r == 2) begin
          old[31] = 1'b0;
          opd[31] = 1'b1;
        end
        run_op(addr, AmoNone, 1'b1, old, 4'hF, core);
        run_op(addr, op, 1'b1, opd, 4'hF, core);
        run_op(addr, AmoNone, 1'b0, '0, 4'h0, core);
      end
    end
  endtask

  task automatic lrsc_test();
    tcdm_addr_t        addr;
    logic [CORE_W-1:0] owner;
    logic [CORE_W-1:0] second;
    logic [CORE_W-1:0] intruder;
    owner    = CORE_W'(2);
    second   = CORE_W'(3);
    intruder = CORE_W'(5);
    addr     = tcdm_addr_t'(random_bits(`TCDM_ADDR_WIDTH));
    run_op(addr, AmoNone, 1'b1, random_bits(32), 4'hF, owner);
    // Clean LR/SC pair succeeds and writes
    run_op(addr, AmoLr, 1'b0, '0, 4'h0, owner);
    run_op(addr, AmoSc, 1'b1, random_bits(32), 4'hF, owner);
    run_op(addr, AmoNone, 1'b0, '0, 4'h0, owner);
    // Reservation already used up
    run_op(addr, AmoSc, 1'b1, random_bits(32), 4'hF, owner);
    run_op(addr, AmoNone, 1'b0, '0, 4'h0, owner);
    // Store from another core in between
    run_op(addr, AmoLr, 1'b0, '0, 4'h0, second);
    run_op(addr, AmoNone, 1'b1, random_bits(32), 4'hF, intruder);
    run_op(addr, AmoSc, 1'b1, random_bits(32), 4'hF, second);
    run_op(addr, AmoNone, 1'b0, '0, 4'h0, second);
  endtask

  task automatic backpressure_test();
    tcdm_addr_t addr_a [N_BP];
    tcdm_meta_t meta_a [N_BP];
    tcdm_word_t exp_a  [N_BP];
    logic       saw_stall;
    int         i;
    int         j;
    saw_stall = 1'b0;
    for (i = 0; i < N_BP; i++) begin
      addr_a[i] = tcdm_addr_t'(random_bits(`TCDM_ADDR_WIDTH));
      run_op(addr_a[i], AmoNone, 1'b1, random_bits(32), 4'hF, random_core());
    end
    // Loads leave the model alone, so expectations are fixed up front
    for (i = 0; i < N_BP; i++) begin
      meta_a[i] = next_meta(random_core());
      exp_a[i]  = model_mem[addr_a[i]];
    end
    rsp_ready_i = 1'b0;
    fork
      begin
        for (i = 0; i < N_BP; i++) begin
          send_request(addr_a[i], AmoNone, 1'b0, '0, 4'h0, meta_a[i]);
        end
      end
      begin
        repeat (6) begin
          @(negedge clk_i);
          #1;
          if (!req_ready_o) saw_stall = 1'b1;
        end
        @(negedge clk_i);
        rsp_ready_i = 1'b1;
        for (j = 0; j < N_BP; j++) begin
          await_response(exp_a[j], meta_a[j]);
        end
      end
    join
    if (!saw_stall) begin
      $display("Error: req_ready_o stayed high while responses were held back");
      other_errors++;
    end
    #1;
    if (rsp_valid_o) begin
      $display("Error: a response appeared that no load asked for");
      other_errors++;
    end
    @(negedge clk_i);
  endtask

  // ------------------------------------------------------------------
  // Run control
  // ------------------------------------------------------------------

  task automatic print_counts();
    $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches,
             other_errors);
  endtask

  initial begin
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_amo_i   = AmoNone;
    req_write_i = 1'b0;
    req_wdata_i = '0;
    req_be_i    = '0;
    req_meta_i  = '0;
    rsp_ready_i = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_flag("req_ready_o", req_ready_o, 1'b1);
    check_flag("rsp_valid_o", rsp_valid_o, 1'b0);
    @(negedge clk_i);
    store_load_test();
    partial_store_test();
    atomic_test();
    lrsc_test();
    backpressure_test();
    print_counts();
    if ((mismatches == 0) && (other_errors == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Generous bound of 40 cycles per operation
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Error: watchdog expired after %0d cycles before the tests finished",
             WATCHDOG_CYCLES);
    other_errors++;
    print_counts();
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
source/tcdm_pkg.sv
source/spill_register.sv
source/fall_through_register.sv
source/amo_alu.sv
source/tcdm_adapter.sv
source/sram_bank.sv
source/tcdm_bank_top.sv
verif/tb_tcdm_bank.sv

// File: Makefile
TOP := tb_tcdm_bank
SIM := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): flist.f include/tcdm_params.svh source/*.sv verif/*.sv
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f flist.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir
